// File: logic/rv_decode_params.svh
// Width and size macros shared by the decode stage modules
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

`define XLEN       32 // Data and register width
`define REG_ADDR_W 5  // Register address width
`define REG_COUNT  32 // Architectural registers
`define PC_W       31 // PC bits 31 down to 1

`endif

// File: logic/rv_isa_pkg.sv
// RISC-V encoding types: major opcodes, funct3 codes and immediate formats
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0, // R type has no immediate
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_J    = 3'd4,
        IMM_U    = 3'd5
    } imm_fmt_e;

    // ALU codes, for OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_MEM_B  = 3'b000; // Stores use B, H and W only
    localparam logic [2:0] F3_MEM_H  = 3'b001;
    localparam logic [2:0] F3_MEM_W  = 3'b010;
    localparam logic [2:0] F3_MEM_BU = 3'b100;
    localparam logic [2:0] F3_MEM_HU = 3'b101;

    localparam logic [2:0] F3_JALR = 3'b000;

endpackage

// File: logic/decode_uop_pkg.sv
// Pipeline-internal types: ALU operation, operand sources, forwarding and micro-op
package decode_uop_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0, // Zero so that a cleared micro-op is harmless
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10 // LUI
    } alu_op_e;

    typedef enum logic {OP_A_REG = 1'b0, OP_A_PC = 1'b1} op_a_sel_e;

    typedef enum logic {OP_B_REG = 1'b0, OP_B_IMM = 1'b1} op_b_sel_e;

    typedef enum logic [1:0] {
        FWD_NONE      = 2'd0,
        FWD_EXECUTE   = 2'd1,
        FWD_WRITEBACK = 2'd2
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e    alu_op;
        op_a_sel_e  op_a_sel;
        op_b_sel_e  op_b_sel;
        logic       is_branch;
        logic       is_jump;
        logic       is_load;
        logic       is_store;
        logic [2:0] mem_funct3; // Branch condition when is_branch
        logic       writes_rd;
    } uop_t;

endpackage

// File: logic/instr_decoder.sv
// Instruction decoder with micro-op table, immediate format select and immediate build
`include "rv_decode_params.svh"

module instr_decoder
    import rv_isa_pkg::*;
    import decode_uop_pkg::*;
(
    input  logic [`XLEN-1:0] instr_i,
    output uop_t             uop_o,
    output logic [`XLEN-1:0] imm_o,
    output logic             invalid_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_fmt_e   imm_fmt;
    uop_t       uop;
    logic       valid;

    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        uop     = '0;
        valid   = 1'b0;
        imm_fmt = IMM_NONE;
        case (opcode)
            OPC_OP: begin
                // Only SUB and SRA use the alternate funct7 so M extension encodings are rejected
                valid = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && funct3 inside {F3_ADD_SUB, F3_SRL_SRA});
                uop.alu_op    = alu_from_funct3(funct3, funct7[5]);
                uop.writes_rd = 1'b1;
            end
            OPC_OP_IMM: begin
                case (funct3)
                    F3_SLL:     valid = (funct7 == 7'b0000000);
                    F3_SRL_SRA: valid = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    default:    valid = 1'b1; // Upper bits are immediate
                endcase
                imm_fmt       = IMM_I;
                uop.alu_op    = alu_from_funct3(funct3, funct3 == F3_SRL_SRA && funct7[5]);
                uop.op_b_sel  = OP_B_IMM;
                uop.writes_rd = 1'b1;
            end
            OPC_LOAD: begin
                valid = funct3 inside {F3_MEM_B, F3_MEM_H, F3_MEM_W, F3_MEM_BU, F3_MEM_HU};
                imm_fmt        = IMM_I;
                uop.op_b_sel   = OP_B_IMM; // Address is rs1 + imm
                uop.is_load    = 1'b1;
                uop.mem_funct3 = funct3;
                uop.writes_rd  = 1'b1;
            end
            OPC_STORE: begin
                valid = funct3 inside {F3_MEM_B, F3_MEM_H, F3_MEM_W};
                imm_fmt        = IMM_S;
                uop.op_b_sel   = OP_B_IMM;
                uop.is_store   = 1'b1;
                uop.mem_funct3 = funct3;
            end
            OPC_BRANCH: begin
                valid = funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
                imm_fmt        = IMM_B;
                uop.op_a_sel   = OP_A_PC; // ALU forms the target
                uop.op_b_sel   = OP_B_IMM;
                uop.is_branch  = 1'b1;
                uop.mem_funct3 = funct3;
            end
            OPC_JAL: begin
                valid         = 1'b1;
                imm_fmt       = IMM_J;
                uop.op_a_sel  = OP_A_PC;
                uop.op_b_sel  = OP_B_IMM;
                uop.is_jump   = 1'b1;
                uop.writes_rd = 1'b1; // Link value is pc_next
            end
            OPC_JALR: begin
                valid         = (funct3 == F3_JALR);
                imm_fmt       = IMM_I;
                uop.op_b_sel  = OP_B_IMM;
                uop.is_jump   = 1'b1;
                uop.writes_rd = 1'b1;
            end
            OPC_LUI: begin
                valid         = 1'b1;
                imm_fmt       = IMM_U;
                uop.alu_op    = ALU_PASS_B;
                uop.op_b_sel  = OP_B_IMM;
                uop.writes_rd = 1'b1;
            end
            OPC_AUIPC: begin
                valid         = 1'b1;
                imm_fmt       = IMM_U;
                uop.op_a_sel  = OP_A_PC;
                uop.op_b_sel  = OP_B_IMM;
                uop.writes_rd = 1'b1;
            end
            default: begin
                valid = 1'b0; // SYSTEM, FENCE and custom opcodes
            end
        endcase
    end

    assign uop_o     = valid ? uop : '0;
    assign invalid_o = !valid;

    always_comb begin
        case (imm_fmt)
            IMM_I:   imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            IMM_S:   imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            IMM_B:   imm_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            IMM_J:   imm_o = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            IMM_U:   imm_o = {instr_i[31:12], 12'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

// File: logic/reg_file.sv
// Register file: 32 entries, two combinational reads, one synchronous write, x0 zero
`include "rv_decode_params.svh"

module reg_file (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o,
    input  logic [`REG_ADDR_W-1:0] rd_addr_i,
    input  logic [`XLEN-1:0]       rd_data_i,
    input  logic                   rd_write_i
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_write_i && rd_addr_i != '0) begin
            regs[rd_addr_i] <= rd_data_i; // x0 never written
        end
    end

    // Same-cycle read sees the old value, bypass is the hazard unit's job
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    a_x0_reads_zero: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (rs1_addr_i == '0 |-> rs1_data_o == '0) and (rs2_addr_i == '0 |-> rs2_data_o == '0)
    ) else $error("x0 read returned a nonzero value");

endmodule

// File: logic/operand_forward.sv
// Operand forwarding muxes, execute operand selection and branch compare flags
`include "rv_decode_params.svh"

module operand_forward
    import decode_uop_pkg::*;
(
    input  logic [`XLEN-1:0] rs1_data_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    input  logic [`XLEN-1:0] ex_fwd_value_i,
    input  logic [`XLEN-1:0] wb_fwd_value_i,
    input  fwd_sel_e         fwd_sel1_i,
    input  fwd_sel_e         fwd_sel2_i,
    input  op_a_sel_e        op_a_sel_i,
    input  op_b_sel_e        op_b_sel_i,
    input  logic [`PC_W-1:0] pc_i,
    input  logic [`XLEN-1:0] imm_i,
    output logic [`XLEN-1:0] operand_a_o,
    output logic [`XLEN-1:0] operand_b_o,
    output logic [`XLEN-1:0] store_data_o,
    output logic [2:0]       cmp_flags_o
);

    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;

    function automatic logic [`XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                 input logic [`XLEN-1:0] reg_value);
        case (sel)
            FWD_EXECUTE:   return ex_fwd_value_i;
            FWD_WRITEBACK: return wb_fwd_value_i;
            default:       return reg_value;
        endcase
    endfunction

    assign src_a = fwd_mux(fwd_sel1_i, rs1_data_i);
    assign src_b = fwd_mux(fwd_sel2_i, rs2_data_i);

    assign operand_a_o  = (op_a_sel_i == OP_A_PC) ? {pc_i, 1'b0} : src_a;
    assign operand_b_o  = (op_b_sel_i == OP_B_IMM) ? imm_i : src_b;
    assign store_data_o = src_b; // rs2 survives the immediate select

    // Signed lt, unsigned lt, equal
    assign cmp_flags_o = {$signed(src_a) < $signed(src_b), src_a < src_b, src_a == src_b};

endmodule

// File: logic/decode_ex_reg.sv
// Decode-to-execute pipeline register with stall and flush
`include "rv_decode_params.svh"

module decode_ex_reg
    import decode_uop_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  uop_t                   uop_i,
    output uop_t                   uop_o,
    input  logic [`XLEN-1:0]       operand_a_i,
    output logic [`XLEN-1:0]       operand_a_o,
    input  logic [`XLEN-1:0]       operand_b_i,
    output logic [`XLEN-1:0]       operand_b_o,
    input  logic [`XLEN-1:0]       store_data_i,
    output logic [`XLEN-1:0]       store_data_o,
    input  logic [2:0]             cmp_flags_i,
    output logic [2:0]             cmp_flags_o,
    input  logic [`REG_ADDR_W-1:0] rd_addr_i,
    output logic [`REG_ADDR_W-1:0] rd_addr_o,
    input  logic [`PC_W-1:0]       pc_i,
    output logic [`PC_W-1:0]       pc_o,
    input  logic [`PC_W-1:0]       pc_next_i,
    output logic [`PC_W-1:0]       pc_next_o,
    input  logic                   invalid_i,
    output logic                   invalid_o
);

    // Reset and flush win over stall, whole bundle cleared
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            uop_o        <= '0;
            operand_a_o  <= '0;
            operand_b_o  <= '0;
            store_data_o <= '0;
            cmp_flags_o  <= '0;
            rd_addr_o    <= '0;
            pc_o         <= '0;
            pc_next_o    <= '0;
            invalid_o    <= 1'b0;
        end else if (!stall_i) begin
            uop_o        <= uop_i;
            operand_a_o  <= operand_a_i;
            operand_b_o  <= operand_b_i;
            store_data_o <= store_data_i;
            cmp_flags_o  <= cmp_flags_i;
            rd_addr_o    <= rd_addr_i;
            pc_o         <= pc_i;
            pc_next_o    <= pc_next_i;
            invalid_o    <= invalid_i;
        end
    end

    a_flush_gives_bubble: assert property (
        @(posedge clk_i) flush_i |=> (uop_o == '0 && !invalid_o)
    ) else $error("Flush did not leave a bubble in execute");

endmodule

// File: logic/decode_stage.sv
// Decode and register-read stage top: decoder, register file, operand logic, stage register
`include "rv_decode_params.svh"

module decode_stage
    import decode_uop_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic [`XLEN-1:0]       if_instr_i,
    input  logic [`PC_W-1:0]       if_pc_i,
    input  logic [`PC_W-1:0]       if_pc_next_i,
    input  logic [`XLEN-1:0]       ex_fwd_value_i,
    input  logic [`REG_ADDR_W-1:0] wb_rd_addr_i,
    input  logic [`XLEN-1:0]       wb_rd_value_i,
    input  logic                   wb_rd_write_i,
    input  logic                   hz_stall_i,
    input  logic                   hz_flush_i,
    input  fwd_sel_e               hz_fwd_sel1_i,
    input  fwd_sel_e               hz_fwd_sel2_i,
    output logic [`REG_ADDR_W-1:0] hz_rs1_addr_o,
    output logic [`REG_ADDR_W-1:0] hz_rs2_addr_o,
    output uop_t                   ex_uop_o,
    output logic [`XLEN-1:0]       ex_operand_a_o,
    output logic [`XLEN-1:0]       ex_operand_b_o,
    output logic [`XLEN-1:0]       ex_store_data_o,
    output logic [2:0]             ex_cmp_flags_o,
    output logic [`REG_ADDR_W-1:0] ex_rd_addr_o,
    output logic [`PC_W-1:0]       ex_pc_o,
    output logic [`PC_W-1:0]       ex_pc_next_o,
    output logic                   ex_invalid_o
);

    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic [`REG_ADDR_W-1:0] rd_addr;
    uop_t                   uop;
    logic [`XLEN-1:0]       imm;
    logic                   invalid;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       operand_a;
    logic [`XLEN-1:0]       operand_b;
    logic [`XLEN-1:0]       store_data;
    logic [2:0]             cmp_flags;

    assign rs1_addr = if_instr_i[19:15];
    assign rs2_addr = if_instr_i[24:20];
    assign rd_addr  = if_instr_i[11:7];

    assign hz_rs1_addr_o = rs1_addr; // Hazard unit compares against later stages
    assign hz_rs2_addr_o = rs2_addr;

    instr_decoder i_instr_decoder (
        .instr_i   (if_instr_i),
        .uop_o     (uop),
        .imm_o     (imm),
        .invalid_o (invalid)
    );

    reg_file i_reg_file (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .rd_addr_i  (wb_rd_addr_i),
        .rd_data_i  (wb_rd_value_i),
        .rd_write_i (wb_rd_write_i)
    );

    operand_forward i_operand_forward (
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .ex_fwd_value_i (ex_fwd_value_i),
        .wb_fwd_value_i (wb_rd_value_i), // Same value the register file writes
        .fwd_sel1_i     (hz_fwd_sel1_i),
        .fwd_sel2_i     (hz_fwd_sel2_i),
        .op_a_sel_i     (uop.op_a_sel),
        .op_b_sel_i     (uop.op_b_sel),
        .pc_i           (if_pc_i),
        .imm_i          (imm),
        .operand_a_o    (operand_a),
        .operand_b_o    (operand_b),
        .store_data_o   (store_data),
        .cmp_flags_o    (cmp_flags)
    );

    decode_ex_reg i_decode_ex_reg (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .stall_i      (hz_stall_i),
        .flush_i      (hz_flush_i),
        .uop_i        (uop),
        .uop_o        (ex_uop_o),
        .operand_a_i  (operand_a),
        .operand_a_o  (ex_operand_a_o),
        .operand_b_i  (operand_b),
        .operand_b_o  (ex_operand_b_o),
        .store_data_i (store_data),
        .store_data_o (ex_store_data_o),
        .cmp_flags_i  (cmp_flags),
        .cmp_flags_o  (ex_cmp_flags_o),
        .rd_addr_i    (rd_addr),
        .rd_addr_o    (ex_rd_addr_o),
        .pc_i         (if_pc_i),
        .pc_o         (ex_pc_o),
        .pc_next_i    (if_pc_next_i),
        .pc_next_o    (ex_pc_next_o),
        .invalid_i    (invalid),
        .invalid_o    (ex_invalid_o)
    );

endmodule

// File: dv/decode_stage_tb.sv
// Directed testbench for the decode stage with clock, reset, value check, test tasks and timeout
`include "rv_decode_params.svh"

module decode_stage_tb
    import rv_isa_pkg::*;
    import decode_uop_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 2000; // Tests take about 100 cycles

    logic                   clk_i;
    logic                   reset_i;
    logic [`XLEN-1:0]       if_instr_i;
    logic [`PC_W-1:0]       if_pc_i;
    logic [`PC_W-1:0]       if_pc_next_i;
    logic [`XLEN-1:0]       ex_fwd_value_i;
    logic [`REG_ADDR_W-1:0] wb_rd_addr_i;
    logic [`XLEN-1:0]       wb_rd_value_i;
    logic                   wb_rd_write_i;
    logic                   hz_stall_i;
    logic                   hz_flush_i;
    fwd_sel_e               hz_fwd_sel1_i;
    fwd_sel_e               hz_fwd_sel2_i;
    logic [`REG_ADDR_W-1:0] hz_rs1_addr_o;
    logic [`REG_ADDR_W-1:0] hz_rs2_addr_o;
    uop_t                   ex_uop_o;
    logic [`XLEN-1:0]       ex_operand_a_o;
    logic [`XLEN-1:0]       ex_operand_b_o;
    logic [`XLEN-1:0]       ex_store_data_o;
    logic [2:0]             ex_cmp_flags_o;
    logic [`REG_ADDR_W-1:0] ex_rd_addr_o;
    logic [`PC_W-1:0]       ex_pc_o;
    logic [`PC_W-1:0]       ex_pc_next_o;
    logic                   ex_invalid_o;

    logic [`XLEN-1:0] rf_model [`REG_COUNT]; // Expected register contents
    int               error_count = 0;
    int               cycle_count = 0;

    decode_stage i_decode_stage (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run exceeded %0d clock cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $fatal(1, "Simulation did not finish in time");
        end
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("[FAIL] t=%0t %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic expect_outputs(input uop_t uop, input logic [31:0] a, input logic [31:0] b,
                                  input logic [31:0] sd, input logic [2:0] flags,
                                  input logic [4:0] rd, input logic [`PC_W-1:0] pc,
                                  input logic [`PC_W-1:0] pc_next, input logic invalid);
        compare_value("ex_uop_o", 32'(uop), 32'(ex_uop_o));
        compare_value("ex_operand_a_o", a, ex_operand_a_o);
        compare_value("ex_operand_b_o", b, ex_operand_b_o);
        compare_value("ex_store_data_o", sd, ex_store_data_o);
        compare_value("ex_cmp_flags_o", 32'(flags), 32'(ex_cmp_flags_o));
        compare_value("ex_rd_addr_o", 32'(rd), 32'(ex_rd_addr_o));
        compare_value("ex_pc_o", 32'(pc), 32'(ex_pc_o));
        compare_value("ex_pc_next_o", 32'(pc_next), 32'(ex_pc_next_o));
        compare_value("ex_invalid_o", 32'(invalid), 32'(ex_invalid_o));
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // Signed lt, unsigned lt, equal
    function automatic logic [2:0] expected_flags(input logic [31:0] a, input logic [31:0] b);
        logic ult;
        logic slt;
        ult = (a < b);
        slt = (a[31] != b[31]) ? a[31] : ult; // Negative side is smaller when signs differ
        return {slt, ult, a == b};
    endfunction

    function automatic logic [31:0] rs1_value(input logic [31:0] instr);
        return rf_model[instr[19:15]];
    endfunction

    function automatic logic [31:0] rs2_value(input logic [31:0] instr);
        return rf_model[instr[24:20]];
    endfunction

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] value);
        @(posedge clk_i);
        wb_rd_addr_i  <= addr;
        wb_rd_value_i <= value;
        wb_rd_write_i <= 1'b1;
        @(posedge clk_i);
        wb_rd_write_i <= 1'b0;
        if (addr != '0) begin
            rf_model[addr] = value; // x0 stays zero
        end
    endtask

    // Drive one instruction and sample after the edge that registers it
    task automatic issue(input logic [31:0] instr, input logic [`PC_W-1:0] pc);
        @(posedge clk_i);
        if_instr_i   <= instr;
        if_pc_i      <= pc;
        if_pc_next_i <= pc + 2; // Next word
        @(posedge clk_i);
        @(negedge clk_i);
    endtask

    task automatic test_reset_and_read();
        uop_t exp;
        exp = '0;
        expect_outputs(exp, 0, 0, 0, 3'b000, 5'd0, 0, 0, 1'b0);
        for (int r = 1; r <= 5; r++) begin
            write_reg(5'(r), $urandom);
        end
        issue(enc_r(7'b0000000, 5'd2, 5'd1, F3_ADD_SUB, 5'd6, OPC_OP), 31'h100);
        exp.alu_op    = ALU_ADD;
        exp.writes_rd = 1'b1;
        compare_value("hz_rs1_addr_o", 32'd1, 32'(hz_rs1_addr_o));
        compare_value("hz_rs2_addr_o", 32'd2, 32'(hz_rs2_addr_o));
        expect_outputs(exp, rf_model[1], rf_model[2], rf_model[2],
                       expected_flags(rf_model[1], rf_model[2]), 5'd6, 31'h100, 31'h102, 1'b0);
    endtask

    task automatic test_immediates();
        uop_t        exp;
        logic [31:0] instr;
        instr = enc_i(12'hFFB, 5'd1, F3_ADD_SUB, 5'd7, OPC_OP_IMM); // ADDI x7, x1, -5
        issue(instr, 31'h200);
        exp           = '0;
        exp.op_b_sel  = OP_B_IMM;
        exp.writes_rd = 1'b1;
        expect_outputs(exp, rf_model[1], 32'hFFFF_FFFB, rs2_value(instr),
                       expected_flags(rf_model[1], rs2_value(instr)), 5'd7, 31'h200, 31'h202, 1'b0);
        instr = enc_s(12'hFF8, 5'd2, 5'd3, F3_MEM_W); // SW x2, -8(x3)
        issue(instr, 31'h210);
        exp            = '0;
        exp.op_b_sel   = OP_B_IMM;
        exp.is_store   = 1'b1;
        exp.mem_funct3 = F3_MEM_W;
        expect_outputs(exp, rf_model[3], 32'hFFFF_FFF8, rf_model[2],
                       expected_flags(rf_model[3], rf_model[2]), instr[11:7],
                       31'h210, 31'h212, 1'b0);
        instr = enc_u(20'hABCDE, 5'd8, OPC_LUI);
        issue(instr, 31'h220);
        exp           = '0;
        exp.alu_op    = ALU_PASS_B;
        exp.op_b_sel  = OP_B_IMM;
        exp.writes_rd = 1'b1;
        expect_outputs(exp, rs1_value(instr), 32'hABCD_E000, rs2_value(instr),
                       expected_flags(rs1_value(instr), rs2_value(instr)), 5'd8,
                       31'h220, 31'h222, 1'b0);
        instr = enc_u(20'h12345, 5'd9, OPC_AUIPC);
        issue(instr, 31'h2000);
        exp.alu_op   = ALU_ADD;
        exp.op_a_sel = OP_A_PC;
        expect_outputs(exp, 32'h0000_4000, 32'h1234_5000, rs2_value(instr),
                       expected_flags(rs1_value(instr), rs2_value(instr)), 5'd9,
                       31'h2000, 31'h2002, 1'b0);
    endtask

    task automatic test_forwarding();
        uop_t        exp;
        logic [31:0] ex_val;
        logic [31:0] wb_val;
        ex_val = $urandom;
        wb_val = $urandom;
        @(posedge clk_i);
        ex_fwd_value_i <= ex_val;
        wb_rd_value_i  <= wb_val;
        hz_fwd_sel1_i  <= FWD_EXECUTE;
        hz_fwd_sel2_i  <= FWD_WRITEBACK;
        issue(enc_r(7'b0000000, 5'd5, 5'd4, F3_ADD_SUB, 5'd10, OPC_OP), 31'h300);
        exp           = '0;
        exp.writes_rd = 1'b1;
        expect_outputs(exp, ex_val, wb_val, wb_val, expected_flags(ex_val, wb_val), 5'd10,
                       31'h300, 31'h302, 1'b0);
        @(posedge clk_i);
        hz_fwd_sel1_i <= FWD_NONE;
        hz_fwd_sel2_i <= FWD_NONE;
        write_reg(5'd0, 32'hDEAD_BEEF);
        issue(enc_r(7'b0000000, 5'd0, 5'd0, F3_ADD_SUB, 5'd11, OPC_OP), 31'h310);
        expect_outputs(exp, 0, 0, 0, 3'b001, 5'd11, 31'h310, 31'h312, 1'b0);
    endtask

    task automatic branch_case(input logic [2:0] f3, input logic [31:0] a,
                               input logic [31:0] b, input logic [2:0] flags);
        uop_t        exp;
        logic [31:0] instr;
        instr = enc_b(13'h1FF0, 5'd2, 5'd1, f3); // Offset -16
        @(posedge clk_i);
        ex_fwd_value_i <= a;
        wb_rd_value_i  <= b;
        issue(instr, 31'h400);
        exp            = '0;
        exp.op_a_sel   = OP_A_PC;
        exp.op_b_sel   = OP_B_IMM;
        exp.is_branch  = 1'b1;
        exp.mem_funct3 = f3;
        expect_outputs(exp, 32'h0000_0800, 32'hFFFF_FFF0, b, flags, instr[11:7],
                       31'h400, 31'h402, 1'b0);
    endtask

    task automatic test_branches();
        uop_t exp;
        @(posedge clk_i);
        hz_fwd_sel1_i <= FWD_EXECUTE;
        hz_fwd_sel2_i <= FWD_WRITEBACK;
        branch_case(F3_BEQ, 32'd5, 32'd5, 3'b001);
        branch_case(F3_BLT, 32'hFFFF_FFFF, 32'd1, 3'b100);
        branch_case(F3_BLTU, 32'd1, 32'h8000_0000, 3'b010);
        branch_case(F3_BLTU, 32'hFFFF_FFFE, 32'hFFFF_FFFF, 3'b110);
        @(posedge clk_i);
        ex_fwd_value_i <= 32'd7;
        wb_rd_value_i  <= 32'd9;
        issue(enc_j(21'h1F_F000, 5'd1), 31'h500); // JAL x1, -4096
        exp           = '0;
        exp.op_a_sel  = OP_A_PC;
        exp.op_b_sel  = OP_B_IMM;
        exp.is_jump   = 1'b1;
        exp.writes_rd = 1'b1;
        expect_outputs(exp, 32'h0000_0A00, 32'hFFFF_F000, 32'd9, 3'b110, 5'd1,
                       31'h500, 31'h502, 1'b0);
        @(posedge clk_i);
        hz_fwd_sel1_i <= FWD_NONE;
        hz_fwd_sel2_i <= FWD_NONE;
    endtask

    task automatic test_stall_flush();
        uop_t exp;
        issue(enc_r(7'b0000000, 5'd2, 5'd1, F3_ADD_SUB, 5'd6, OPC_OP), 31'h600);
        exp           = '0;
        exp.writes_rd = 1'b1;
        // First pass recaptures the ADD and the next three run under stall
        for (int c = 1; c <= 4; c++) begin
            @(posedge clk_i);
            hz_stall_i <= 1'b1;
            if_instr_i <= enc_u(20'(c), 5'(c), OPC_LUI);
            if_pc_i    <= 31'h700;
            @(negedge clk_i);
            expect_outputs(exp, rf_model[1], rf_model[2], rf_model[2],
                           expected_flags(rf_model[1], rf_model[2]), 5'd6,
                           31'h600, 31'h602, 1'b0);
        end
        @(posedge clk_i);
        hz_flush_i <= 1'b1;
        @(posedge clk_i);
        hz_flush_i <= 1'b0;
        hz_stall_i <= 1'b0;
        @(negedge clk_i);
        exp = '0;
        expect_outputs(exp, 0, 0, 0, 3'b000, 5'd0, 0, 0, 1'b0);
    endtask

    task automatic test_invalid();
        uop_t        exp;
        logic [31:0] instr;
        exp = '0;
        issue(32'h0000_0073, 31'h800); // ECALL from the SYSTEM opcode
        expect_outputs(exp, 0, 0, 0, 3'b001, 5'd0, 31'h800, 31'h802, 1'b1);
        instr = enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd12, 7'b0001011); // custom-0
        issue(instr, 31'h810);
        expect_outputs(exp, rf_model[1], rf_model[2], rf_model[2],
                       expected_flags(rf_model[1], rf_model[2]), 5'd12, 31'h810, 31'h812, 1'b1);
        instr = enc_r(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd13, OPC_OP); // MUL
        issue(instr, 31'h820);
        expect_outputs(exp, rf_model[1], rf_model[2], rf_model[2],
                       expected_flags(rf_model[1], rf_model[2]), 5'd13, 31'h820, 31'h822, 1'b1);
    endtask

    initial begin
        void'($urandom(44));
        for (int i = 0; i < `REG_COUNT; i++) begin
            rf_model[i] = '0;
        end
        reset_i        = 1'b1;
        if_instr_i     = '0;
        if_pc_i        = '0;
        if_pc_next_i   = '0;
        ex_fwd_value_i = '0;
        wb_rd_addr_i   = '0;
        wb_rd_value_i  = '0;
        wb_rd_write_i  = 1'b0;
        hz_stall_i     = 1'b0;
        hz_flush_i     = 1'b0;
        hz_fwd_sel1_i  = FWD_NONE;
        hz_fwd_sel2_i  = FWD_NONE;
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        test_reset_and_read();
        test_immediates();
        test_forwarding();
        test_branches();
        test_stall_flush();
        test_invalid();
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/decode_uop_pkg.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/operand_forward.sv
logic/decode_ex_reg.sv
logic/decode_stage.sv
dv/decode_stage_tb.sv

// File: Makefile
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
